/* hw/textDisplay_cfg.svh */
`ifndef TEXT_DISPLAY_CFG_SVH
`define TEXT_DISPLAY_CFG_SVH

// screen geometry in character cells
`define TEXT_COLS       80
`define TEXT_ROWS       60
`define CELL_PIX        8
`define GLYPHS_PER_WORD 3
`define WORDS_PER_ROW   27          // 81 slots, the last one never shown
`define SCREEN_W        (`TEXT_COLS * `CELL_PIX)
`define SCREEN_H        (`TEXT_ROWS * `CELL_PIX)

// memories
`define TEXT_DEPTH      4096
`define GLYPH_COUNT     16
`define GLYPH_WORDS     4           // two bitmap rows per word

// APB map
`define REG_TEXT_COLOR  16'h8000
`define REG_BACK_COLOR  16'h8004
`define REG_BLANK       16'h8008
`define REG_PAGE_BASE   16'h800C
`define TEXT_WINDOW_END 16'h3FFC

`endif

/* hw/textDisplayPkg.sv */
`default_nettype none

package textDisplayPkg;

	////////////////////
	// scan side
	typedef logic [9:0]  pixCoord_t;  // 1-based, 0 is off screen
	typedef logic [17:0] textWord_t;  // three glyph codes
	typedef logic [11:0] textAddr_t;
	typedef logic [5:0]  glyphCode_t;
	typedef logic [17:0] glyphWord_t; // two rows in bits 15..0
	typedef logic [7:0]  rgb_t;

	////////////////////
	// bus side
	typedef logic [15:0] apbAddr_t;
	typedef logic [31:0] apbData_t;

endpackage

`default_nettype wire

/* hw/pixelStageIf.sv */
`timescale 1ns/1ps
`default_nettype none

// staged selectors, each one aligned to the stage that consumes it
interface pixelStageIf;
	import textDisplayPkg::*;

	textAddr_t  textAddr;   // valid after edge N
	logic [1:0] slot;       // valid after edge N+1
	logic [1:0] glyphRow;   // bitmap word within the glyph
	logic [3:0] bitIndex;   // valid after edge N+2
	logic       visible;

	modport ctrl (
		output textAddr,
		output slot,
		output glyphRow,
		output bitIndex,
		output visible
	);

	modport mem (
		input textAddr
	);

	modport glyph (
		input slot,
		input glyphRow
	);

	modport color (
		input bitIndex,
		input visible
	);

endinterface

`default_nettype wire

/* hw/textScanControl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "textDisplay_cfg.svh"

module textScanControl (
	input  wire logic                   CLK,
	input  wire logic                   arstN,
	input  wire textDisplayPkg::pixCoord_t hPix,
	input  wire textDisplayPkg::pixCoord_t vPix,
	input  wire textDisplayPkg::textAddr_t pageBase,
	pixelStageIf.ctrl                   stage
);
	import textDisplayPkg::*;

	pixCoord_t  col;        // zero-based pixel column
	pixCoord_t  row;
	logic [6:0] cellCol;
	logic [6:0] cellRow;
	textAddr_t  addrNext;
	logic       visNext;

	logic [1:0] slotD1;
	logic [1:0] glyphRowD1;
	logic [3:0] bitIndexD1;
	logic [3:0] bitIndexD2;
	logic       visD1;
	logic       visD2;

	assign col = hPix - 10'd1;  // wraps for 0, masked by visible
	assign row = vPix - 10'd1;
	assign cellCol = 7'(col / `CELL_PIX);
	assign cellRow = 7'(row / `CELL_PIX);

	// word address wraps at the memory size, so pages may straddle the top
	assign addrNext = pageBase + textAddr_t'(cellCol / `GLYPHS_PER_WORD)
		+ textAddr_t'(cellRow * `WORDS_PER_ROW);

	assign visNext = (hPix != 10'd0) && (hPix <= `SCREEN_W) &&
		(vPix != 10'd0) && (vPix <= `SCREEN_H);

	////////////////////
	// selector pipeline
	always_ff @(posedge CLK) begin
		stage.textAddr <= addrNext;                                 // edge N
		slotD1 <= 2'(cellCol % `GLYPHS_PER_WORD);
		glyphRowD1 <= 2'((row % `CELL_PIX) / 2);
		bitIndexD1 <= 4'(col % `CELL_PIX + `CELL_PIX * (row % 2)); // odd rows use bits 7..0
		stage.slot <= slotD1;                                       // edge N+1
		stage.glyphRow <= glyphRowD1;
		bitIndexD2 <= bitIndexD1;
		stage.bitIndex <= bitIndexD2;                               // edge N+2
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			visD1 <= 1'b0;
			visD2 <= 1'b0;
			stage.visible <= 1'b0;
		end else begin
			visD1 <= visNext;
			visD2 <= visD1;
			stage.visible <= visD2;
		end
	end

	// visible trails the address by two stages
	assert property (@(posedge CLK) disable iff (!arstN)
		stage.visible |-> !$isunknown($past(stage.textAddr, 2)));

endmodule

`default_nettype wire

/* hw/apbDisplayRegs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "textDisplay_cfg.svh"

module apbDisplayRegs (
	input  wire logic                   CLK,
	input  wire logic                   arstN,
	input  wire logic                   pSel,
	input  wire logic                   pEnable,
	input  wire logic                   pWrite,
	input  wire textDisplayPkg::apbAddr_t pAddr,
	input  wire textDisplayPkg::apbData_t pWData,
	output textDisplayPkg::apbData_t    pRData,
	output logic                        pReady,
	output logic                        pSlvErr,
	output logic                        wrEn,
	output textDisplayPkg::textAddr_t   wrAddr,
	output textDisplayPkg::textWord_t   wrData,
	output textDisplayPkg::rgb_t        textColor,
	output textDisplayPkg::rgb_t        backColor,
	output logic                        blank,
	output textDisplayPkg::textAddr_t   pageBase
);
	import textDisplayPkg::*;

	logic     setup;
	logic     access;
	logic     textHit;
	logic     regHit;
	logic     errNext;
	apbData_t rdNext;

	assign setup = pSel && !pEnable;
	assign access = pSel && pEnable;
	assign textHit = (pAddr <= `TEXT_WINDOW_END);
	assign regHit = (pAddr == `REG_TEXT_COLOR) || (pAddr == `REG_BACK_COLOR) ||
		(pAddr == `REG_BLANK) || (pAddr == `REG_PAGE_BASE);
	assign errNext = textHit ? !pWrite : !regHit; // text window is write only
	assign pReady = 1'b1;

	// text memory port, commits at the end of the access cycle
	assign wrEn = access && pWrite && textHit;
	assign wrAddr = pAddr[13:2];
	assign wrData = pWData[17:0];

	always_comb begin
		case (pAddr)
			`REG_TEXT_COLOR: rdNext = {24'h0, textColor};
			`REG_BACK_COLOR: rdNext = {24'h0, backColor};
			`REG_BLANK:      rdNext = {31'h0, blank};
			`REG_PAGE_BASE:  rdNext = {20'h0, pageBase};
			default:         rdNext = '0;
		endcase
	end

	////////////////////
	// response is prepared during setup and held through access
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pRData <= '0;
			pSlvErr <= 1'b0;
		end else begin
			pRData <= (setup && !pWrite) ? rdNext : '0;
			pSlvErr <= setup && errNext;
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			textColor <= 8'hFF;
			backColor <= 8'h00;
			blank <= 1'b0;
			pageBase <= '0;
		end else if (access && pWrite) begin
			case (pAddr)
				`REG_TEXT_COLOR: textColor <= pWData[7:0];
				`REG_BACK_COLOR: backColor <= pWData[7:0];
				`REG_BLANK:      blank <= pWData[0];
				`REG_PAGE_BASE:  pageBase <= pWData[11:0];
				default: ;                              // text window or unmapped
			endcase
		end
	end

	assert property (@(posedge CLK) disable iff (!arstN)
		access |-> $past(setup));
	assert property (@(posedge CLK) disable iff (!arstN)
		access |-> $stable(pAddr));

endmodule

`default_nettype wire

/* hw/textMemory.sv */
`timescale 1ns/1ps
`default_nettype none
`include "textDisplay_cfg.svh"

// screen text, 27 words per text row
module textMemory (
	input  wire logic                     CLK,
	input  wire logic                     wrEn,
	input  wire textDisplayPkg::textAddr_t wrAddr,
	input  wire textDisplayPkg::textWord_t wrData,
	pixelStageIf.mem                      stage,
	output textDisplayPkg::textWord_t     word
);
	import textDisplayPkg::*;

	textWord_t mem [`TEXT_DEPTH];

	////////////////////
	// bus write port
	always_ff @(posedge CLK) begin
		if (wrEn) begin
			mem[wrAddr] <= wrData;
		end
	end

	////////////////////
	// scan read port
	// old data is returned when both ports hit one word
	always_ff @(posedge CLK) begin
		word <= mem[stage.textAddr];  // presented after edge N+1
	end

	// a committed write carries a known address and known data
	assert property (@(posedge CLK)
		wrEn |-> !$isunknown({wrAddr, wrData}));

endmodule

`default_nettype wire

/* hw/glyphRom.sv */
`timescale 1ns/1ps
`default_nettype none
`include "textDisplay_cfg.svh"

module glyphRom (
	input  wire logic                     CLK,
	input  wire logic                     arstN,
	input  wire textDisplayPkg::textWord_t word,
	pixelStageIf.glyph                    stage,
	output textDisplayPkg::glyphWord_t    bitmap
);
	import textDisplayPkg::*;

	localparam int ROM_DEPTH = `GLYPH_COUNT * `GLYPH_WORDS;
	localparam int CODE_BITS = $clog2(`GLYPH_COUNT);

	glyphWord_t rom [ROM_DEPTH];
	glyphCode_t code;
	logic [$clog2(ROM_DEPTH)-1:0] romAddr;
	logic inRange;

	initial begin
		$readmemb("hw/glyphs.mem", rom);
	end

	// leftmost cell sits in the top six bits
	always_comb begin
		case (stage.slot)
			2'd0:    code = word[17:12];
			2'd1:    code = word[11:6];
			default: code = word[5:0];
		endcase
	end

	assign romAddr = {code[CODE_BITS-1:0], stage.glyphRow}; // code*4 + row pair
	assign inRange = (code < `GLYPH_COUNT);

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			bitmap <= '0;
		end else begin
			bitmap <= inRange ? rom[romAddr] : '0;  // codes past the ROM draw nothing
		end
	end

endmodule

`default_nettype wire

/* hw/pixelColor.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelColor (
	input  wire logic                      CLK,
	input  wire logic                      arstN,
	input  wire textDisplayPkg::glyphWord_t bitmap,
	pixelStageIf.color                     stage,
	input  wire textDisplayPkg::rgb_t      textColor,
	input  wire textDisplayPkg::rgb_t      backColor,
	input  wire logic                      blank,
	output textDisplayPkg::rgb_t           rgb
);
	import textDisplayPkg::*;

	logic pixOn;

	// even rows sit in bits 15..8, odd rows in 7..0, leftmost pixel highest
	assign pixOn = bitmap[4'd15 - stage.bitIndex];

	////////////////////
	// output color
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			rgb <= '0;
		end else if (!stage.visible || blank) begin
			rgb <= '0;                              // border or blanked screen
		end else begin
			rgb <= pixOn ? textColor : backColor;
		end
	end

endmodule

`default_nettype wire

/* hw/textDisplay.sv */
`timescale 1ns/1ps
`default_nettype none

module textDisplay (
	input  wire logic                     CLK,
	input  wire logic                     arstN,
	input  wire logic                     pSel,
	input  wire logic                     pEnable,
	input  wire logic                     pWrite,
	input  wire textDisplayPkg::apbAddr_t  pAddr,
	input  wire textDisplayPkg::apbData_t  pWData,
	output wire textDisplayPkg::apbData_t  pRData,
	output wire logic                     pReady,
	output wire logic                     pSlvErr,
	input  wire textDisplayPkg::pixCoord_t hPix,
	input  wire textDisplayPkg::pixCoord_t vPix,
	output wire textDisplayPkg::rgb_t      rgb
);
	import textDisplayPkg::*;

	logic       wrEn;
	textAddr_t  wrAddr;
	textWord_t  wrData;
	rgb_t       textColor;
	rgb_t       backColor;
	logic       blank;
	textAddr_t  pageBase;
	textWord_t  word;
	glyphWord_t bitmap;

	pixelStageIf stage ();

	////////////////////
	// bus side
	apbDisplayRegs regs0 (
		.CLK(CLK), .arstN(arstN),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWData(pWData), .pRData(pRData),
		.pReady(pReady), .pSlvErr(pSlvErr),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.textColor(textColor), .backColor(backColor),
		.blank(blank), .pageBase(pageBase)
	);

	////////////////////
	// scan pipeline, rgb three edges after the coordinate
	textScanControl scan0 (
		.CLK(CLK), .arstN(arstN),
		.hPix(hPix), .vPix(vPix),
		.pageBase(pageBase),
		.stage(stage.ctrl)
	);

	textMemory mem0 (
		.CLK(CLK),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.stage(stage.mem),
		.word(word)
	);

	glyphRom glyph0 (
		.CLK(CLK), .arstN(arstN),
		.word(word),
		.stage(stage.glyph),
		.bitmap(bitmap)
	);

	pixelColor color0 (
		.CLK(CLK), .arstN(arstN),
		.bitmap(bitmap),
		.stage(stage.color),
		.textColor(textColor), .backColor(backColor),
		.blank(blank),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

/* verification/textDisplayTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "textDisplay_cfg.svh"

module textDisplayTb;
	import textDisplayPkg::*;

	localparam int HALF_PERIOD = 50;
	localparam int DRIVE_DELAY = 10;
	localparam int APB_TIMEOUT = 16;
	localparam int PIPE_STEPS = 4;  // drive edge, sample edge, then three stages

	logic      CLK;
	logic      arstN;
	logic      pSel;
	logic      pEnable;
	logic      pWrite;
	apbAddr_t  pAddr;
	apbData_t  pWData;
	apbData_t  pRData;
	logic      pReady;
	logic      pSlvErr;
	pixCoord_t hPix;
	pixCoord_t vPix;
	rgb_t      rgb;

	glyphWord_t glyphModel [`GLYPH_COUNT * `GLYPH_WORDS];
	textWord_t  shadow [`TEXT_DEPTH];       // every text word written over the bus
	logic       shadowValid [`TEXT_DEPTH];
	rgb_t       curText;
	rgb_t       curBack;
	logic       curBlank;

	int   hTab[$];
	int   vTab[$];
	rgb_t expTab[$];

	string testName;
	int    testCount;
	int    checkCount;
	int    errorCount;
	int    testChecks;
	int    testErrors;

	textDisplay dut0 (
		.CLK(CLK), .arstN(arstN),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWData(pWData), .pRData(pRData),
		.pReady(pReady), .pSlvErr(pSlvErr),
		.hPix(hPix), .vPix(vPix), .rgb(rgb)
	);

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	////////////////////
	// bookkeeping
	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testCount++;
		testChecks = checkCount;
		testErrors = errorCount;
	endtask

	task automatic finishTest();
		$display("test %0d %s: %0d checks, %0d errors", testCount, testName,
			checkCount - testChecks, errorCount - testErrors);
	endtask

	////////////////////
	// APB master
	task automatic apbTransfer(input logic write, input apbAddr_t addr, input apbData_t data,
		output apbData_t rdData, output logic err);
		int waitCnt;
		@(posedge CLK);
		#DRIVE_DELAY;
		pSel = 1'b1;     // setup cycle
		pEnable = 1'b0;
		pWrite = write;
		pAddr = addr;
		pWData = data;
		@(posedge CLK);
		#DRIVE_DELAY;
		pEnable = 1'b1;
		waitCnt = 0;
		while (pReady !== 1'b1 && waitCnt < APB_TIMEOUT) begin
			@(posedge CLK);
			#DRIVE_DELAY;
			waitCnt++;
		end
		if (pReady !== 1'b1) begin
			errorCount++;
			$display("APB transfer to %h got no pReady within %0d cycles", addr, APB_TIMEOUT);
		end
		rdData = pRData;
		err = pSlvErr;
		@(posedge CLK);  // transfer completes here
		#DRIVE_DELAY;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
	endtask

	task automatic writeAndCheck(input apbAddr_t addr, input apbData_t data, input logic expErr);
		apbData_t rdData;
		logic     err;
		apbTransfer(1'b1, addr, data, rdData, err);
		checkValue("pSlvErr", err, expErr);
	endtask

	task automatic readAndCheck(input apbAddr_t addr, input apbData_t expData, input logic expErr);
		apbData_t rdData;
		logic     err;
		apbTransfer(1'b0, addr, '0, rdData, err);
		checkValue("pSlvErr", err, expErr);
		if (!expErr) begin
			checkValue("pRData", rdData, expData);
		end
	endtask

	task automatic writeText(input int index, input textWord_t word);
		writeAndCheck(apbAddr_t'(index * 4), {14'h0, word}, 1'b0);
		shadow[index] = word;
		shadowValid[index] = 1'b1;
	endtask

	task automatic writeRandomWords(input int first, input int count);
		logic [31:0] r;
		int          k;
		for (k = 0; k < count; k++) begin
			r = $urandom();
			writeText(first + k, {2'b00, r[11:8], 2'b00, r[7:4], 2'b00, r[3:0]}); // codes 0..15
		end
	endtask

	task automatic writeHighCodes(input int first, input int count);
		glyphCode_t c0;
		glyphCode_t c1;
		glyphCode_t c2;
		int         k;
		for (k = 0; k < count; k++) begin
			c0 = glyphCode_t'(`GLYPH_COUNT + $urandom() % 48);
			c1 = glyphCode_t'(`GLYPH_COUNT + $urandom() % 48);
			c2 = glyphCode_t'(`GLYPH_COUNT + $urandom() % 48);
			writeText(first + k, {c0, c1, c2});
		end
	endtask

	////////////////////
	// pixel model
	function automatic rgb_t expectedPixel(input int h, input int v, input int page);
		int         col;
		int         row;
		int         cellCol;
		int         cellRow;
		int         addr;
		int         code;
		int         bitIdx;
		glyphWord_t bits;
		if (h == 0 || h > `SCREEN_W || v == 0 || v > `SCREEN_H || curBlank) begin
			return 8'h00;
		end
		col = h - 1;
		row = v - 1;
		cellCol = col / `CELL_PIX;
		cellRow = row / `CELL_PIX;
		addr = (page + cellCol / `GLYPHS_PER_WORD + cellRow * `WORDS_PER_ROW) % `TEXT_DEPTH;
		if (!shadowValid[addr]) begin
			errorCount++;
			$display("pixel (%0d,%0d) needs text word %0d, which was never written", h, v, addr);
		end
		code = (shadow[addr] >> (12 - 6 * (cellCol % `GLYPHS_PER_WORD))) & 6'h3F;
		if (code >= `GLYPH_COUNT) begin
			bits = '0;
		end else begin
			bits = glyphModel[code * `GLYPH_WORDS + (row % `CELL_PIX) / 2];
		end
		bitIdx = col % `CELL_PIX + `CELL_PIX * (row % 2);
		return bits[15 - bitIdx] ? curText : curBack;
	endfunction

	////////////////////
	// stimulus table
	task automatic clearTable();
		hTab.delete();
		vTab.delete();
		expTab.delete();
	endtask

	task automatic addRow(input int h, input int v, input rgb_t exp);
		hTab.push_back(h);
		vTab.push_back(v);
		expTab.push_back(exp);
	endtask

	task automatic addCell(input int cellRow, input int cellCol, input int page);
		int px;
		int py;
		int h;
		int v;
		for (py = 0; py < `CELL_PIX; py++) begin
			for (px = 0; px < `CELL_PIX; px++) begin
				h = cellCol * `CELL_PIX + px + 1;
				v = cellRow * `CELL_PIX + py + 1;
				addRow(h, v, expectedPixel(h, v, page));
			end
		end
	endtask

	task automatic addCellColor(input int cellRow, input int cellCol, input rgb_t color);
		int px;
		int py;
		for (py = 0; py < `CELL_PIX; py++) begin
			for (px = 0; px < `CELL_PIX; px++) begin
				addRow(cellCol * `CELL_PIX + px + 1, cellRow * `CELL_PIX + py + 1, color);
			end
		end
	endtask

	// one coordinate per cycle, rgb checked once it leaves the pipeline
	task automatic runTable();
		int n;
		int j;
		n = hTab.size();
		for (j = 0; j < n + PIPE_STEPS; j++) begin
			@(posedge CLK);
			#DRIVE_DELAY;
			if (j >= PIPE_STEPS) begin
				checkValue($sformatf("rgb(h=%0d,v=%0d)", hTab[j - PIPE_STEPS], vTab[j - PIPE_STEPS]),
					rgb, expTab[j - PIPE_STEPS]);
			end
			if (j < n) begin
				hPix = pixCoord_t'(hTab[j]);
				vPix = pixCoord_t'(vTab[j]);
			end else begin
				hPix = '0;
				vPix = '0;
			end
		end
	endtask

	initial begin
		int i;
		int cc;
		arstN = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		hPix = '0;
		vPix = '0;
		testCount = 0;
		checkCount = 0;
		errorCount = 0;
		curText = 8'hFF;
		curBack = 8'h00;
		curBlank = 1'b0;
		void'($urandom(3));
		for (i = 0; i < `TEXT_DEPTH; i++) begin
			shadowValid[i] = 1'b0;
		end
		$readmemb("hw/glyphs.mem", glyphModel);
		repeat (8) @(posedge CLK);
		#DRIVE_DELAY;
		arstN = 1'b1;

		startTest("register reset and readback");
		checkValue("pSlvErr", pSlvErr, 1'b0);
		checkValue("pRData", pRData, 32'h0);
		checkValue("rgb", rgb, 8'h00);
		readAndCheck(`REG_TEXT_COLOR, 32'hFF, 1'b0);
		readAndCheck(`REG_BACK_COLOR, 32'h00, 1'b0);
		readAndCheck(`REG_BLANK, 32'h0, 1'b0);
		readAndCheck(`REG_PAGE_BASE, 32'h0, 1'b0);
		writeAndCheck(`REG_TEXT_COLOR, 32'h123456A5, 1'b0);
		writeAndCheck(`REG_BACK_COLOR, 32'h3C, 1'b0);
		writeAndCheck(`REG_BLANK, 32'h1, 1'b0);
		writeAndCheck(`REG_PAGE_BASE, 32'hFFFFF123, 1'b0);  // only 12 bits kept
		readAndCheck(`REG_TEXT_COLOR, 32'hA5, 1'b0);
		readAndCheck(`REG_BACK_COLOR, 32'h3C, 1'b0);
		readAndCheck(`REG_BLANK, 32'h1, 1'b0);
		readAndCheck(`REG_PAGE_BASE, 32'h123, 1'b0);
		writeAndCheck(`REG_BLANK, 32'h0, 1'b0);
		writeAndCheck(`REG_PAGE_BASE, 32'h0, 1'b0);
		curText = 8'hA5;
		curBack = 8'h3C;
		finishTest();

		startTest("bus errors");
		readAndCheck(16'h0010, 32'h0, 1'b1);
		readAndCheck(`TEXT_WINDOW_END, 32'h0, 1'b1);
		writeAndCheck(16'h4000, 32'h77, 1'b1);
		writeAndCheck(16'h8001, 32'h77, 1'b1);  // misaligned register
		writeAndCheck(16'h8010, 32'h77, 1'b1);
		readAndCheck(16'h9000, 32'h0, 1'b1);
		readAndCheck(`REG_TEXT_COLOR, 32'hA5, 1'b0);
		readAndCheck(`REG_BACK_COLOR, 32'h3C, 1'b0);
		readAndCheck(`REG_BLANK, 32'h0, 1'b0);
		readAndCheck(`REG_PAGE_BASE, 32'h0, 1'b0);
		finishTest();

		startTest("random glyphs on page 0");
		writeRandomWords(0, 3 * `WORDS_PER_ROW);
		writeRandomWords(59 * `WORDS_PER_ROW, `WORDS_PER_ROW);
		clearTable();
		for (cc = 0; cc < 6; cc++) begin
			addCell(0, cc, 0);
			addCell(1, cc, 0);
		end
		addCell(2, 40, 0);
		addCell(59, 78, 0);  // bottom right corner
		addCell(59, 79, 0);
		runTable();
		finishTest();

		startTest("border and blank");
		clearTable();
		addRow(0, 1, 8'h00);
		addRow(1, 0, 8'h00);
		addRow(0, 0, 8'h00);
		addRow(641, 1, 8'h00);
		addRow(640, 481, 8'h00);
		addRow(1023, 200, 8'h00);
		addRow(1, 1, expectedPixel(1, 1, 0));
		addRow(640, 480, expectedPixel(640, 480, 0));
		runTable();
		writeAndCheck(`REG_BLANK, 32'h1, 1'b0);
		curBlank = 1'b1;
		clearTable();
		addCellColor(0, 0, 8'h00);
		addCellColor(1, 4, 8'h00);
		runTable();
		writeAndCheck(`REG_BLANK, 32'h0, 1'b0);
		curBlank = 1'b0;
		finishTest();

		startTest("page flip");
		writeRandomWords(2048, 3 * `WORDS_PER_ROW);
		writeText(2048, {6'd1, 6'd3, 6'd15});
		writeAndCheck(`REG_PAGE_BASE, 32'd2048, 1'b0);
		clearTable();
		for (cc = 0; cc < 6; cc++) begin
			addCell(0, cc, 2048);
			addCell(2, cc + 20, 2048);
		end
		runTable();
		finishTest();

		startTest("codes past the glyph ROM");
		writeText(3000, {6'd16, 6'd40, 6'd63});
		writeHighCodes(3001, 2);
		writeHighCodes(3000 + `WORDS_PER_ROW, 3);
		writeAndCheck(`REG_PAGE_BASE, 32'd3000, 1'b0);
		clearTable();
		for (cc = 0; cc < 9; cc++) begin
			addCellColor(0, cc, curBack);
			addCellColor(1, cc, curBack);
		end
		runTable();
		finishTest();

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* textDisplay.f */
// glyph bitmaps are read from hw/glyphs.mem, so run the simulator from the project root
+incdir+hw
hw/textDisplayPkg.sv
hw/pixelStageIf.sv
hw/textScanControl.sv
hw/apbDisplayRegs.sv
hw/textMemory.sv
hw/glyphRom.sv
hw/pixelColor.sv
hw/textDisplay.sv
verification/textDisplayTb.sv

/* hw/glyphs.mem */
// one 18-bit word per line: bits 17..16 unused, 15..8 even pixel row, 7..0 odd pixel row
// four words per glyph, top row pair first, glyph 0 at the top of the file
000000000000000000
000000000000000000
000000000000000000
000000000000000000
001111111111111111
001111111111111111
001111111111111111
001111111111111111
001010101001010101
001010101001010101
001010101001010101
001010101001010101
001111111110000001
001000000110000001
001000000110000001
001000000111111111
000001100000100100
000100001001000010
000111111001000010
000100001000000000
000111110001000010
000100001001111100
000100001001000010
000111110000000000
000011110001000010
000100000001000000
000100000001000010
000011110000000000
000100001001000010
000100001001111110
000100001001000010
000100001000000000
000011110000011000
000001100000011000
000001100000011000
000011110000000000
000011110001000110
000100101001010010
000110001001000010
000011110000000000
000001100000111000
000001100000011000
000001100000011000
000111111000000000
001111000011110000
001111000011110000
001111000011110000
001111000011110000
001111111100000000
001111111100000000
001111111100000000
001111111100000000
001000000001000000
000010000000010000
000000100000000100
000000001000000001
000000000100000010
000000010000001000
000001000000100000
000100000010000000
001000000101000010
000010010000011000
000001100000100100
000100001010000001
